// File: hw/rvPkg.sv
package rvPkg;

   localparam int XLen        = 32;
   localparam int RegAddrBits = 5;

   typedef logic [XLen-1:0]        wordT;
   typedef logic [RegAddrBits-1:0] regAddrT;

   localparam wordT ResetPc = '0;

   // RV32I major opcodes kept by this core
   typedef enum logic [6:0] {
      opCompute    = 7'b0110011,
      opComputeImm = 7'b0010011,
      opBranch     = 7'b1100011,
      opLoad       = 7'b0000011,
      opStore      = 7'b0100011,
      opJal        = 7'b1101111,
      opJalr       = 7'b1100111,
      opLui        = 7'b0110111,
      opAuipc      = 7'b0010111
   } opcodeE;

   typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSelE;

   typedef enum logic [1:0] {resAlu, resPc4, resImm} execResultE;

   typedef struct packed {
      logic valid;
      logic halt;
      wordT pc;
      wordT instr;
   } ifIdT;

   typedef struct packed {
      logic       valid;
      logic       halt;
      wordT       pc;
      wordT       rs1Data;
      wordT       rs2Data;
      wordT       imm;
      regAddrT    rd;
      logic       regWrite;
      logic       memRead;
      logic       memWrite;
      logic       isBranch;
      logic       isJump;
      logic       aSelPc;
      logic       bSelImm;
      execResultE execResult;
      logic [2:0] funct3;
      logic       altFunct;   // Bit 30, sub and sra
      logic       isCompute;
   } idExT;

   typedef struct packed {
      logic    valid;
      logic    halt;
      wordT    result;
      wordT    storeData;
      regAddrT rd;
      logic    regWrite;
      logic    memRead;
      logic    memWrite;
   } exMemT;

   typedef struct packed {
      logic    valid;
      regAddrT rd;
      logic    regWrite;
      wordT    wbData;
   } memWbT;

   typedef struct packed {
      logic taken;
      wordT target;
   } redirectT;

endpackage

// File: hw/regFile.sv
`timescale 1ns/1ps
module regFile import rvPkg::*; (
   input  logic    clk,
   input  regAddrT raddr1,
   input  regAddrT raddr2,
   output wordT    rdata1,
   output wordT    rdata2,
   input  regAddrT waddr,
   input  wordT    wdata,
   input  logic    wen
);
   wordT regs [32];

   always_ff @(posedge clk) begin
      if (wen && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
   assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

   assert property (@(posedge clk) (raddr2 == '0) |-> (rdata2 == '0));

endmodule

// File: hw/fetchStage.sv
`timescale 1ns/1ps
module fetchStage import rvPkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  logic     stall,
   input  redirectT redirect,
   input  logic     halt,
   output wordT     imemAddr,
   input  wordT     imemData,
   output ifIdT     ifId
);
   wordT pc;
   wordT pcNext;
   logic misaligned;

   assign imemAddr   = pc;
   assign misaligned = pc[1:0] != 2'b00;

   always_comb begin
      if (redirect.taken) begin
         pcNext = redirect.target;
      end else if (stall || halt) begin
         pcNext = pc;
      end else begin
         pcNext = pc + 32'd4;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= ResetPc;
      end else begin
         pc <= pcNext;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN || redirect.taken) begin
         ifId.valid <= 1'b0;
         ifId.halt  <= 1'b0;
      end else if (!stall) begin
         ifId.valid <= !halt;        // No new work once halted
         ifId.halt  <= misaligned;
         ifId.pc    <= pc;
         ifId.instr <= imemData;
      end
   end

endmodule

// File: hw/decodeStage.sv
`timescale 1ns/1ps
module decodeStage import rvPkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  logic     stall,
   input  redirectT redirect,
   input  ifIdT     ifId,
   input  memWbT    memWb,
   output idExT     idEx
);
   wordT    instr;
   opcodeE  opcode;
   regAddrT rs1;
   regAddrT rs2;
   wordT    rfData1;
   wordT    rfData2;
   logic    wbWrite;
   immSelE  immSel;
   logic    unknownOp;
   idExT    idNext;

   assign instr   = ifId.instr;
   assign opcode  = opcodeE'(instr[6:0]);
   assign rs1     = instr[19:15];
   assign rs2     = instr[24:20];
   assign wbWrite = memWb.valid && memWb.regWrite && memWb.rd != '0;

   regFile regs0 (
      .clk,
      .raddr1(rs1),
      .raddr2(rs2),
      .rdata1(rfData1),
      .rdata2(rfData2),
      .waddr(memWb.rd),
      .wdata(memWb.wbData),
      .wen(wbWrite)
   );

   always_comb begin
      idNext    = '0;
      immSel    = immI;
      unknownOp = 1'b0;
      case (opcode)
         opCompute: begin
            idNext.regWrite  = 1'b1;
            idNext.isCompute = 1'b1;
         end
         opComputeImm: begin
            idNext.regWrite  = 1'b1;
            idNext.isCompute = 1'b1;
            idNext.bSelImm   = 1'b1;
         end
         opBranch: begin
            immSel          = immB;
            idNext.isBranch = 1'b1;
            idNext.aSelPc   = 1'b1;
            idNext.bSelImm  = 1'b1;
         end
         opLoad: begin
            idNext.regWrite = 1'b1;
            idNext.memRead  = 1'b1;
            idNext.bSelImm  = 1'b1;
         end
         opStore: begin
            immSel          = immS;
            idNext.memWrite = 1'b1;
            idNext.bSelImm  = 1'b1;
         end
         opJal: begin
            immSel            = immJ;
            idNext.regWrite   = 1'b1;
            idNext.isJump     = 1'b1;
            idNext.aSelPc     = 1'b1;
            idNext.bSelImm    = 1'b1;
            idNext.execResult = resPc4;
         end
         opJalr: begin
            idNext.regWrite   = 1'b1;
            idNext.isJump     = 1'b1;
            idNext.bSelImm    = 1'b1;
            idNext.execResult = resPc4;
         end
         opLui: begin
            immSel            = immU;
            idNext.regWrite   = 1'b1;
            idNext.bSelImm    = 1'b1;
            idNext.execResult = resImm;
         end
         opAuipc: begin
            immSel          = immU;
            idNext.regWrite = 1'b1;
            idNext.aSelPc   = 1'b1;
            idNext.bSelImm  = 1'b1;
         end
         default: unknownOp = 1'b1;
      endcase

      case (immSel)
         immS:    idNext.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         immB:    idNext.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                instr[11:8], 1'b0};
         immU:    idNext.imm = {instr[31:12], 12'b0};
         immJ:    idNext.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
         default: idNext.imm = {{20{instr[31]}}, instr[31:20]};
      endcase

      idNext.valid   = ifId.valid;
      idNext.halt    = ifId.valid && (ifId.halt || unknownOp);
      idNext.pc      = ifId.pc;
      // Same-cycle writeback wins over the array
      idNext.rs1Data = (wbWrite && memWb.rd == rs1) ? memWb.wbData : rfData1;
      idNext.rs2Data = (wbWrite && memWb.rd == rs2) ? memWb.wbData : rfData2;
      idNext.rd      = instr[11:7];
      idNext.funct3  = instr[14:12];
      // Bit 30 is immediate data for addi
      idNext.altFunct = instr[30] && (opcode == opCompute || instr[14:12] == 3'b101);
   end

   always_ff @(posedge clk) begin
      if (!rstN || stall || redirect.taken) begin
         idEx.valid <= 1'b0;
         idEx.halt  <= 1'b0;
      end else begin
         idEx <= idNext;
      end
   end

endmodule

// File: hw/hazardUnit.sv
`timescale 1ns/1ps
module hazardUnit import rvPkg::*; (
   input  ifIdT  ifId,
   input  idExT  idEx,
   input  exMemT exMem,
   output logic  stall
);
   regAddrT rs1;
   regAddrT rs2;
   logic    exWrites;
   logic    memWrites;
   logic    exHit;
   logic    memHit;

   // Unused source fields may stall needlessly
   assign rs1 = ifId.instr[19:15];
   assign rs2 = ifId.instr[24:20];

   assign exWrites  = idEx.valid && idEx.regWrite && idEx.rd != '0;
   assign memWrites = exMem.valid && exMem.regWrite && exMem.rd != '0;
   assign exHit     = exWrites && (idEx.rd == rs1 || idEx.rd == rs2);
   assign memHit    = memWrites && (exMem.rd == rs1 || exMem.rd == rs2);
   assign stall     = ifId.valid && (exHit || memHit);

endmodule

// File: hw/executeStage.sv
`timescale 1ns/1ps
module executeStage import rvPkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  idExT     idEx,
   output redirectT redirect,
   output exMemT    exMem
);
   wordT opA;
   wordT opB;
   wordT aluOut;
   wordT result;
   logic condTrue;
   logic badCond;

   assign opA = idEx.aSelPc ? idEx.pc : idEx.rs1Data;
   assign opB = idEx.bSelImm ? idEx.imm : idEx.rs2Data;

   always_comb begin
      aluOut = opA + opB;   // Address and link math
      if (idEx.isCompute) begin
         case (idEx.funct3)
            3'b000:  aluOut = idEx.altFunct ? opA - opB : opA + opB;
            3'b001:  aluOut = opA << opB[4:0];
            3'b010:  aluOut = {{(XLen-1){1'b0}}, $signed(opA) < $signed(opB)};
            3'b011:  aluOut = {{(XLen-1){1'b0}}, opA < opB};
            3'b100:  aluOut = opA ^ opB;
            3'b101: begin
               if (idEx.altFunct) begin
                  aluOut = $signed(opA) >>> opB[4:0];
               end else begin
                  aluOut = opA >> opB[4:0];
               end
            end
            3'b110:  aluOut = opA | opB;
            default: aluOut = opA & opB;
         endcase
      end
   end

   // Branch compare on register values
   always_comb begin
      badCond = 1'b0;
      case (idEx.funct3)
         3'b000:  condTrue = idEx.rs1Data == idEx.rs2Data;
         3'b001:  condTrue = idEx.rs1Data != idEx.rs2Data;
         3'b100:  condTrue = $signed(idEx.rs1Data) < $signed(idEx.rs2Data);
         3'b101:  condTrue = $signed(idEx.rs1Data) >= $signed(idEx.rs2Data);
         3'b110:  condTrue = idEx.rs1Data < idEx.rs2Data;
         3'b111:  condTrue = idEx.rs1Data >= idEx.rs2Data;
         default: begin
            condTrue = 1'b0;
            badCond  = 1'b1;
         end
      endcase
   end

   assign redirect = '{taken: idEx.valid && (idEx.isJump || (idEx.isBranch && condTrue)),
                       target: aluOut};

   always_comb begin
      case (idEx.execResult)
         resPc4:  result = idEx.pc + 32'd4;
         resImm:  result = idEx.imm;
         default: result = aluOut;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         exMem.valid <= 1'b0;
         exMem.halt  <= 1'b0;
      end else begin
         exMem.valid     <= idEx.valid;
         exMem.halt      <= idEx.valid && (idEx.halt || (idEx.isBranch && badCond));
         exMem.result    <= result;
         exMem.storeData <= idEx.rs2Data;
         exMem.rd        <= idEx.rd;
         exMem.regWrite  <= idEx.regWrite;
         exMem.memRead   <= idEx.memRead;
         exMem.memWrite  <= idEx.memWrite;
      end
   end

   // A redirect comes from a real instruction, and the slot behind it is squashed
   assert property (@(posedge clk) disable iff (!rstN)
      redirect.taken |-> idEx.valid ##1 !idEx.valid);

endmodule

// File: hw/memAccessStage.sv
`timescale 1ns/1ps
module memAccessStage import rvPkg::*; (
   input  logic  clk,
   input  logic  rstN,
   input  exMemT exMem,
   output wordT  dmemAddr,
   output wordT  dmemWrData,
   output logic  dmemWrEn,
   input  wordT  dmemRdData,
   output memWbT memWb,
   output logic  halt
);
   logic misaligned;
   logic flagged;

   assign misaligned = (exMem.memRead || exMem.memWrite) && exMem.result[1:0] != 2'b00;
   assign flagged    = exMem.valid && (exMem.halt || misaligned);

   assign dmemAddr   = exMem.result;
   assign dmemWrData = exMem.storeData;
   assign dmemWrEn   = exMem.valid && exMem.memWrite && !flagged && !halt;

   // Sticky until reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         halt <= 1'b0;
      end else if (flagged) begin
         halt <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         memWb.valid    <= 1'b0;
         memWb.regWrite <= 1'b0;
      end else begin
         memWb.valid    <= exMem.valid;
         memWb.regWrite <= exMem.valid && exMem.regWrite && !flagged && !halt;
         memWb.rd       <= exMem.rd;
         memWb.wbData   <= exMem.memRead ? dmemRdData : exMem.result;
      end
   end

   assert property (@(posedge clk) disable iff (!rstN) dmemWrEn |-> dmemAddr[1:0] == 2'b00);

endmodule

// File: hw/rvCore.sv
`timescale 1ns/1ps
module rvCore import rvPkg::*; (
   input  logic clk,
   input  logic rstN,
   output wordT imemAddr,
   input  wordT imemData,
   output wordT dmemAddr,
   output wordT dmemWrData,
   output logic dmemWrEn,
   input  wordT dmemRdData,
   output logic halt
);
   ifIdT     ifId;
   idExT     idEx;
   exMemT    exMem;
   memWbT    memWb;
   redirectT redirect;
   logic     stall;

   fetchStage fetch0 (
      .clk, .rstN, .stall, .redirect, .halt, .imemAddr, .imemData, .ifId
   );

   decodeStage decode0 (
      .clk, .rstN, .stall, .redirect, .ifId, .memWb, .idEx
   );

   executeStage execute0 (
      .clk, .rstN, .idEx, .redirect, .exMem
   );

   memAccessStage memAccess0 (
      .clk, .rstN, .exMem, .dmemAddr, .dmemWrData, .dmemWrEn, .dmemRdData, .memWb, .halt
   );

   hazardUnit hazard0 (
      .ifId, .idEx, .exMem, .stall
   );

endmodule

// File: verification/rvCoreTb.sv
`timescale 1ns/1ps
module rvCoreTb import rvPkg::*; ();
   localparam int NumRows       = 11;
   localparam int MaxWords      = 12;
   localparam int MaxStores     = 6;
   localparam int TimeoutCycles = 2000;
   localparam int DrainCycles   = 8;

   logic clk;
   logic rstN;
   wordT imemAddr;
   wordT imemData;
   wordT dmemAddr;
   wordT dmemWrData;
   logic dmemWrEn;
   wordT dmemRdData;
   logic halt;

   wordT imem [64];
   wordT dmem [64];
   wordT gotAddr [$];
   wordT gotData [$];

   // One row per program
   wordT progTab [NumRows][MaxWords];
   wordT expAddr [NumRows][MaxStores];
   wordT expData [NumRows][MaxStores];
   int   wordCount [NumRows];
   int   expCount [NumRows];
   logic expHalt [NumRows];
   int   numRows;
   int   checks;
   int   errors;

   rvCore dut0 (
      .clk, .rstN, .imemAddr, .imemData, .dmemAddr, .dmemWrData, .dmemWrEn, .dmemRdData, .halt
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Memories answer half a cycle after the address moves
   always @(negedge clk) begin
      imemData   = imem[imemAddr[7:2]];
      dmemRdData = dmem[dmemAddr[7:2]];
   end

   always @(posedge clk) begin
      if (rstN && dmemWrEn) begin
         dmem[dmemAddr[7:2]] = dmemWrData;
         gotAddr.push_back(dmemAddr);
         gotData.push_back(dmemWrData);
      end
   end

   function automatic wordT rType(input logic [6:0] f7, input regAddrT rs2, input regAddrT rs1,
                                  input logic [2:0] f3, input regAddrT rd);
      return {f7, rs2, rs1, f3, rd, opCompute};
   endfunction

   function automatic wordT iType(input logic [11:0] imm, input regAddrT rs1,
                                  input logic [2:0] f3, input regAddrT rd, input opcodeE op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic wordT sType(input logic [11:0] imm, input regAddrT rs2, input regAddrT rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
   endfunction

   function automatic wordT bType(input logic [12:0] imm, input regAddrT rs2, input regAddrT rs1,
                                  input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
   endfunction

   function automatic wordT uType(input logic [19:0] imm, input regAddrT rd, input opcodeE op);
      return {imm, rd, op};
   endfunction

   function automatic wordT jType(input logic [20:0] imm, input regAddrT rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
   endfunction

   task automatic putInstr(input wordT w);
      progTab[numRows][wordCount[numRows]] = w;
      wordCount[numRows]++;
   endtask

   task automatic expectStore(input wordT addr, input wordT data);
      expAddr[numRows][expCount[numRows]] = addr;
      expData[numRows][expCount[numRows]] = data;
      expCount[numRows]++;
   endtask

   task automatic endRow();
      putInstr('0);   // Unknown opcode halts the core
      expHalt[numRows] = 1'b1;
      numRows++;
   endtask

   task automatic buildTable();
      int r;
      int w;
      for (r = 0; r < NumRows; r++) begin
         for (w = 0; w < MaxWords; w++) begin
            progTab[r][w] = '0;
         end
         wordCount[r] = 0;
         expCount[r]  = 0;
         expHalt[r]   = 1'b0;
      end
      numRows = 0;

      // add, sub, slli, slt
      putInstr(iType(12'h123, 5'd0, 3'b000, 5'd1, opComputeImm));
      putInstr(iType(12'hFFB, 5'd0, 3'b000, 5'd2, opComputeImm));
      putInstr(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
      putInstr(sType(12'h000, 5'd3, 5'd0));
      putInstr(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
      putInstr(sType(12'h004, 5'd4, 5'd0));
      putInstr(iType(12'h004, 5'd1, 3'b001, 5'd5, opComputeImm));
      putInstr(sType(12'h008, 5'd5, 5'd0));
      putInstr(rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd6));
      putInstr(sType(12'h00C, 5'd6, 5'd0));
      expectStore(32'h00, 32'h0000011E);
      expectStore(32'h04, 32'h00000128);
      expectStore(32'h08, 32'h00001230);
      expectStore(32'h0C, 32'h00000001);
      endRow();

      // sltu, xor, srli, srai
      putInstr(iType(12'hFFB, 5'd0, 3'b000, 5'd1, opComputeImm));
      putInstr(iType(12'h0F0, 5'd0, 3'b000, 5'd2, opComputeImm));
      putInstr(rType(7'h00, 5'd1, 5'd2, 3'b011, 5'd3));
      putInstr(sType(12'h020, 5'd3, 5'd0));
      putInstr(rType(7'h00, 5'd2, 5'd1, 3'b100, 5'd4));
      putInstr(sType(12'h024, 5'd4, 5'd0));
      putInstr(iType(12'h004, 5'd1, 3'b101, 5'd5, opComputeImm));
      putInstr(sType(12'h028, 5'd5, 5'd0));
      putInstr(iType(12'h401, 5'd1, 3'b101, 5'd6, opComputeImm));
      putInstr(sType(12'h02C, 5'd6, 5'd0));
      expectStore(32'h20, 32'h00000001);
      expectStore(32'h24, 32'hFFFFFF0B);
      expectStore(32'h28, 32'h0FFFFFFF);
      expectStore(32'h2C, 32'hFFFFFFFD);
      endRow();

      // or, and, sll, srl
      putInstr(iType(12'h5A5, 5'd0, 3'b000, 5'd1, opComputeImm));
      putInstr(iType(12'h0FF, 5'd0, 3'b000, 5'd2, opComputeImm));
      putInstr(rType(7'h00, 5'd2, 5'd1, 3'b110, 5'd3));
      putInstr(sType(12'h030, 5'd3, 5'd0));
      putInstr(rType(7'h00, 5'd2, 5'd1, 3'b111, 5'd4));
      putInstr(sType(12'h034, 5'd4, 5'd0));
      putInstr(iType(12'h003, 5'd0, 3'b000, 5'd5, opComputeImm));
      putInstr(rType(7'h00, 5'd5, 5'd1, 3'b001, 5'd6));
      putInstr(sType(12'h038, 5'd6, 5'd0));
      putInstr(rType(7'h00, 5'd5, 5'd6, 3'b101, 5'd7));
      putInstr(sType(12'h03C, 5'd7, 5'd0));
      expectStore(32'h30, 32'h000005FF);
      expectStore(32'h34, 32'h000000A5);
      expectStore(32'h38, 32'h00002D28);
      expectStore(32'h3C, 32'h000005A5);
      endRow();

      // Store, load back, store the loaded word
      putInstr(uType(20'h12345, 5'd1, opLui));
      putInstr(iType(12'h678, 5'd1, 3'b000, 5'd1, opComputeImm));
      putInstr(iType(12'h040, 5'd0, 3'b000, 5'd2, opComputeImm));
      putInstr(sType(12'h000, 5'd1, 5'd2));
      putInstr(iType(12'h000, 5'd2, 3'b010, 5'd3, opLoad));
      putInstr(sType(12'h004, 5'd3, 5'd2));
      expectStore(32'h40, 32'h12345678);
      expectStore(32'h44, 32'h12345678);
      endRow();

      putInstr(iType(12'hFFF, 5'd0, 3'b000, 5'd1, opComputeImm));
      putInstr(iType(12'h001, 5'd0, 3'b000, 5'd2, opComputeImm));
      putInstr(bType(13'h008, 5'd2, 5'd1, 3'b000));   // beq, falls through
      putInstr(sType(12'h050, 5'd2, 5'd0));
      putInstr(bType(13'h008, 5'd2, 5'd1, 3'b001));   // bne taken
      putInstr(sType(12'h054, 5'd2, 5'd0));
      putInstr(bType(13'h008, 5'd2, 5'd1, 3'b100));   // blt taken
      putInstr(sType(12'h058, 5'd2, 5'd0));
      putInstr(bType(13'h008, 5'd2, 5'd1, 3'b110));   // bltu, falls through
      putInstr(sType(12'h05C, 5'd1, 5'd0));
      expectStore(32'h50, 32'h00000001);
      expectStore(32'h5C, 32'hFFFFFFFF);
      endRow();

      putInstr(iType(12'hFFF, 5'd0, 3'b000, 5'd1, opComputeImm));
      putInstr(iType(12'h001, 5'd0, 3'b000, 5'd2, opComputeImm));
      putInstr(bType(13'h00C, 5'd1, 5'd2, 3'b101));   // bge taken over both slots
      putInstr(sType(12'h060, 5'd2, 5'd0));
      putInstr(sType(12'h064, 5'd2, 5'd0));
      putInstr(sType(12'h068, 5'd1, 5'd0));
      putInstr(bType(13'h008, 5'd1, 5'd2, 3'b111));   // bgeu, falls through
      putInstr(sType(12'h06C, 5'd2, 5'd0));
      putInstr(bType(13'h008, 5'd1, 5'd1, 3'b000));   // beq taken
      putInstr(sType(12'h070, 5'd2, 5'd0));
      putInstr(sType(12'h074, 5'd2, 5'd0));
      expectStore(32'h68, 32'hFFFFFFFF);
      expectStore(32'h6C, 32'h00000001);
      expectStore(32'h74, 32'h00000001);
      endRow();

      putInstr(iType(12'hFFF, 5'd0, 3'b000, 5'd1, opComputeImm));
      putInstr(iType(12'h001, 5'd0, 3'b000, 5'd2, opComputeImm));
      putInstr(bType(13'h008, 5'd1, 5'd2, 3'b110));   // bltu taken
      putInstr(sType(12'h080, 5'd2, 5'd0));
      putInstr(bType(13'h008, 5'd2, 5'd1, 3'b111));   // bgeu taken
      putInstr(sType(12'h084, 5'd2, 5'd0));
      // bne, blt and bge fall through, a wrong jump lands on the halt word
      putInstr(bType(13'h010, 5'd1, 5'd1, 3'b001));
      putInstr(bType(13'h00C, 5'd1, 5'd2, 3'b100));
      putInstr(bType(13'h008, 5'd2, 5'd1, 3'b101));
      putInstr(sType(12'h088, 5'd1, 5'd0));
      expectStore(32'h88, 32'hFFFFFFFF);
      endRow();

      // Link values of jal and jalr
      putInstr(jType(21'h000008, 5'd1));
      putInstr(sType(12'h090, 5'd0, 5'd0));
      putInstr(sType(12'h094, 5'd1, 5'd0));
      putInstr(iType(12'h01C, 5'd0, 3'b000, 5'd2, opComputeImm));
      putInstr(iType(12'h000, 5'd2, 3'b000, 5'd3, opJalr));
      putInstr(sType(12'h098, 5'd0, 5'd0));
      putInstr(sType(12'h09C, 5'd0, 5'd0));
      putInstr(sType(12'h0A0, 5'd3, 5'd0));
      expectStore(32'h94, 32'h00000004);
      expectStore(32'hA0, 32'h00000014);
      endRow();

      putInstr(uType(20'hABCDE, 5'd4, opLui));
      putInstr(sType(12'h0A4, 5'd4, 5'd0));
      putInstr(uType(20'h00010, 5'd5, opAuipc));
      putInstr(sType(12'h0A8, 5'd5, 5'd0));
      expectStore(32'hA4, 32'hABCDE000);
      expectStore(32'hA8, 32'h00010008);
      endRow();

      // Unknown opcode in the middle
      putInstr(iType(12'h007, 5'd0, 3'b000, 5'd1, opComputeImm));
      putInstr(sType(12'h0B0, 5'd1, 5'd0));
      putInstr(32'hFFFFFFFF);
      putInstr(sType(12'h0B4, 5'd1, 5'd0));
      putInstr(sType(12'h0B8, 5'd1, 5'd0));
      expectStore(32'hB0, 32'h00000007);
      endRow();

      putInstr(iType(12'h009, 5'd0, 3'b000, 5'd1, opComputeImm));
      putInstr(sType(12'h0C0, 5'd1, 5'd0));
      putInstr(iType(12'h0C2, 5'd0, 3'b000, 5'd2, opComputeImm));
      putInstr(sType(12'h000, 5'd1, 5'd2));            // Misaligned
      putInstr(sType(12'h0C4, 5'd1, 5'd0));
      expectStore(32'hC0, 32'h00000009);
      endRow();
   endtask

   task automatic checkWord(input string what, input wordT got, input wordT exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got 0x%08h, expected 0x%08h", what, got, exp);
      end
   endtask

   task automatic checkStoreCount(input int r, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("error store count row %0d: got 0x%0h, expected 0x%0h", r, got, exp);
      end
   endtask

   task automatic checkHalt(input int r, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error halt row %0d: got 0x%0h, expected 0x%0h", r, got, exp);
      end
   endtask

   task automatic runRow(input int r);
      int i;
      int cycles;
      @(negedge clk);
      rstN = 1'b0;
      @(posedge clk);
      for (i = 0; i < 64; i++) begin
         imem[i] = '0;
         if (i < MaxWords) begin
            imem[i] = progTab[r][i];
         end
         dmem[i] = 32'hDA7A0000 + 32'(i * 4);
      end
      gotAddr.delete();
      gotData.delete();
      repeat (10) @(negedge clk);
      rstN = 1'b1;
      checkWord($sformatf("imemAddr row %0d after reset", r), imemAddr, 32'h00000000);
      checkHalt(r, halt, 1'b0);

      cycles = 0;
      while (!halt && cycles < TimeoutCycles) begin
         @(negedge clk);
         cycles++;
      end
      if (!halt) begin
         errors++;
         $display("row %0d timed out after %0d cycles without halt", r, TimeoutCycles);
      end

      // Younger instructions still drain toward memory access
      repeat (DrainCycles) @(negedge clk);

      checkHalt(r, halt, expHalt[r]);
      checkStoreCount(r, gotAddr.size(), expCount[r]);
      for (i = 0; i < expCount[r] && i < gotAddr.size(); i++) begin
         checkWord($sformatf("dmemAddr row %0d store %0d", r, i), gotAddr[i], expAddr[r][i]);
         checkWord($sformatf("dmemWrData row %0d store %0d", r, i), gotData[i], expData[r][i]);
      end
   endtask

   initial begin
      int r;
      rstN       = 1'b0;
      imemData   = '0;
      dmemRdData = '0;
      checks     = 0;
      errors     = 0;
      buildTable();
      for (r = 0; r < numRows; r++) begin
         runRow(r);
      end
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: sources.f
hw/rvPkg.sv
hw/regFile.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/hazardUnit.sv
hw/executeStage.sv
hw/memAccessStage.sv
hw/rvCore.sv
verification/rvCoreTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = rvCoreTb
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log
FAILMSG   = FAIL: see errors above

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAILMSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
